// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cache_manage_tb -f vlog.f -o cache_manage_sim

./obj_dir/cache_manage_sim > sim.log
cat sim.log

grep -q "All tests passed!" sim.log

// ==== src/cache_manage.sv ====
`timescale 1ns/1ps

module cache_manage #(
    parameter int ICACHE_SETS = 16,
    parameter int DCACHE_SETS = 16
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  cache_pkg::ibus_req_t   ireq,
    output cache_pkg::ibus_resp_t  iresp,
    input  cache_pkg::dbus_req_t   dreq_1,
    output cache_pkg::dbus_resp_t  dresp_1,
    input  cache_pkg::dbus_req_t   dreq_2,
    output cache_pkg::dbus_resp_t  dresp_2,
    output cache_pkg::cbus_req_t   creq,
    input  cache_pkg::cbus_resp_t  cresp
);

    // icache, uncached 2, dcache, uncached 1
    localparam int CBUS_MASTERS = 4;

    function automatic cache_pkg::addr_t translate(input cache_pkg::addr_t vaddr);
        logic [2:0] seg;
        seg = vaddr[31:29];
        if ((seg & cache_pkg::SEG_MASK) == (cache_pkg::UNCACHED_SEG & cache_pkg::SEG_MASK)) begin
            return {3'b000, vaddr[28:0]};
        end
        return vaddr;
    endfunction

    logic uncached_1;
    logic uncached_2;
    logic route_1;
    logic route_2;

    cache_pkg::ibus_req_t  ic_req;
    cache_pkg::dbus_req_t  dc_req_1;
    cache_pkg::dbus_req_t  dc_req_2;
    cache_pkg::dbus_req_t  unc_req_1;
    cache_pkg::dbus_req_t  unc_req_2;
    cache_pkg::dbus_resp_t dc_resp_1;
    cache_pkg::dbus_resp_t dc_resp_2;
    cache_pkg::dbus_resp_t unc_resp_1;
    cache_pkg::dbus_resp_t unc_resp_2;

    cache_pkg::cbus_req_t  ic_creq;
    cache_pkg::cbus_req_t  dc_creq;
    cache_pkg::cbus_req_t  unc_creq_1;
    cache_pkg::cbus_req_t  unc_creq_2;
    cache_pkg::cbus_resp_t ic_cresp;
    cache_pkg::cbus_resp_t dc_cresp;
    cache_pkg::cbus_resp_t unc_cresp_1;
    cache_pkg::cbus_resp_t unc_cresp_2;

    cache_pkg::cbus_req_t  [CBUS_MASTERS-1:0] arb_reqs;
    cache_pkg::cbus_resp_t [CBUS_MASTERS-1:0] arb_resps;

    assign uncached_1 = dreq_1.addr[31:29] == cache_pkg::UNCACHED_SEG;
    assign uncached_2 = dreq_2.addr[31:29] == cache_pkg::UNCACHED_SEG;

    always_comb begin
        ic_req = ireq;
        ic_req.addr = translate(ireq.addr);

        dc_req_1 = dreq_1;
        dc_req_1.addr = translate(dreq_1.addr);
        unc_req_1 = dc_req_1;
        dc_req_1.valid = dreq_1.valid && !uncached_1;
        unc_req_1.valid = dreq_1.valid && uncached_1;

        // port 2 keeps its own dcache port even when port 1 is idle
        dc_req_2 = dreq_2;
        dc_req_2.addr = translate(dreq_2.addr);
        unc_req_2 = dc_req_2;
        dc_req_2.valid = dreq_2.valid && !uncached_2;
        unc_req_2.valid = dreq_2.valid && uncached_2;
    end

    // request is held until data_ok, so the last seen class is the live one
    always_ff @(posedge clk) begin
        if (resetn) begin
            route_1 <= 1'b0;
            route_2 <= 1'b0;
        end else begin
            if (dreq_1.valid) begin
                route_1 <= uncached_1;
            end
            if (dreq_2.valid) begin
                route_2 <= uncached_2;
            end
        end
    end

    assign dresp_1 = route_1 ? unc_resp_1 : dc_resp_1;
    assign dresp_2 = route_2 ? unc_resp_2 : dc_resp_2;

    assign arb_reqs = {unc_creq_1, dc_creq, unc_creq_2, ic_creq};
    assign {unc_cresp_1, dc_cresp, unc_cresp_2, ic_cresp} = arb_resps;

    icache #(
        .ICACHE_SETS(ICACHE_SETS)
    ) icache_i (
        .clk(clk),
        .resetn(resetn),
        .ireq(ic_req),
        .iresp(iresp),
        .icreq(ic_creq),
        .icresp(ic_cresp)
    );

    dcache #(
        .DCACHE_SETS(DCACHE_SETS)
    ) dcache_i (
        .clk(clk),
        .resetn(resetn),
        .dreq_1(dc_req_1),
        .dresp_1(dc_resp_1),
        .dreq_2(dc_req_2),
        .dresp_2(dc_resp_2),
        .dcreq(dc_creq),
        .dcresp(dc_cresp)
    );

    dbus_to_cbus uncached_1_i (
        .clk(clk),
        .resetn(resetn),
        .dreq(unc_req_1),
        .dresp(unc_resp_1),
        .dcreq(unc_creq_1),
        .dcresp(unc_cresp_1)
    );

    dbus_to_cbus uncached_2_i (
        .clk(clk),
        .resetn(resetn),
        .dreq(unc_req_2),
        .dresp(unc_resp_2),
        .dcreq(unc_creq_2),
        .dcresp(unc_cresp_2)
    );

    cbus_arbiter #(
        .NUM_INPUTS(CBUS_MASTERS)
    ) cbus_arbiter_i (
        .clk(clk),
        .resetn(resetn),
        .ireqs(arb_reqs),
        .iresps(arb_resps),
        .oreq(creq),
        .oresp(cresp)
    );

    // a response must belong to a request still on the port
    a_dresp_1_has_req: assert property (@(posedge clk) disable iff (resetn)
        dresp_1.data_ok |-> dreq_1.valid);
    a_dresp_2_has_req: assert property (@(posedge clk) disable iff (resetn)
        dresp_2.data_ok |-> dreq_2.valid);

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strobe_t;
    typedef logic [1:0]  msize_t;

    // kseg0 and kseg1 share the top two bits, kseg1 is uncached
    localparam logic [2:0] SEG_MASK     = 3'b110;
    localparam logic [2:0] UNCACHED_SEG = 3'b101;

    localparam msize_t MSIZE_WORD = 2'b10;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        word_t [1:0] data;
    } ibus_resp_t;

    typedef struct packed {
        logic    valid;
        addr_t   addr;
        msize_t  size;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    typedef struct packed {
        logic  addr_ok;
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed {
        logic       valid;
        logic       is_write;
        msize_t     size;
        addr_t      addr;
        strobe_t    strobe;
        word_t      data;
        logic [1:0] len;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

endpackage

// ==== src/cbus_arbiter.sv ====
`timescale 1ns/1ps

module cbus_arbiter #(
    parameter int NUM_INPUTS = 4
) (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  cache_pkg::cbus_req_t  [NUM_INPUTS-1:0] ireqs,
    output cache_pkg::cbus_resp_t [NUM_INPUTS-1:0] iresps,
    output cache_pkg::cbus_req_t                   oreq,
    input  cache_pkg::cbus_resp_t                  oresp
);

    localparam int IDX_W = $clog2(NUM_INPUTS);

    logic busy;
    logic [IDX_W-1:0] index;
    logic [IDX_W-1:0] next_index;
    logic [IDX_W-1:0] grant;

    // lowest index wins
    always_comb begin
        next_index = '0;
        for (int i = NUM_INPUTS - 1; i >= 0; i--) begin
            if (ireqs[i].valid) begin
                next_index = IDX_W'(i);
            end
        end
    end

    assign grant = busy ? index : next_index;
    assign oreq = ireqs[grant];

    always_comb begin
        for (int i = 0; i < NUM_INPUTS; i++) begin
            iresps[i] = (IDX_W'(i) == grant) ? oresp : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy <= 1'b0;
            index <= '0;
        end else if (busy) begin
            if (oresp.ready && oresp.last) begin
                busy <= 1'b0;
            end
        end else if (oreq.valid) begin
            busy <= !(oresp.ready && oresp.last);
            index <= next_index;
        end
    end

    // the granted master keeps its request up to the last beat
    a_grant_held: assert property (@(posedge clk) disable iff (resetn)
        busy |-> ireqs[index].valid);

endmodule

// ==== src/dbus_to_cbus.sv ====
`timescale 1ns/1ps

module dbus_to_cbus (
    input  logic                  clk,
    input  logic                  resetn,
    input  cache_pkg::dbus_req_t  dreq,
    output cache_pkg::dbus_resp_t dresp,
    output cache_pkg::cbus_req_t  dcreq,
    input  cache_pkg::cbus_resp_t dcresp
);

    logic done;
    cache_pkg::word_t data_q;

    // single beat, held until the bus takes it
    always_comb begin
        dcreq.valid = dreq.valid && !done && !resetn;
        dcreq.is_write = |dreq.strobe;
        dcreq.size = dreq.size;
        dcreq.addr = dreq.addr;
        dcreq.strobe = dreq.strobe;
        dcreq.data = dreq.data;
        dcreq.len = 2'd0;
    end

    // high for the response cycle only
    always_ff @(posedge clk) begin
        if (resetn) begin
            done <= 1'b0;
        end else begin
            done <= dcreq.valid && dcresp.ready && dcresp.last;
        end
    end

    always_ff @(posedge clk) begin
        if (dcresp.ready) begin
            data_q <= dcresp.data;
        end
    end

    assign dresp.addr_ok = done;
    assign dresp.data_ok = done;
    assign dresp.data = data_q;

endmodule

// ==== src/dcache.sv ====
`timescale 1ns/1ps

module dcache #(
    parameter int DCACHE_SETS = 16
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  cache_pkg::dbus_req_t  dreq_1,
    output cache_pkg::dbus_resp_t dresp_1,
    input  cache_pkg::dbus_req_t  dreq_2,
    output cache_pkg::dbus_resp_t dresp_2,
    output cache_pkg::cbus_req_t  dcreq,
    input  cache_pkg::cbus_resp_t dcresp
);

    localparam int IDX_W = $clog2(DCACHE_SETS);
    localparam int TAG_W = 32 - 4 - IDX_W;

    typedef enum logic [1:0] {IDLE, FILL, WRITE, RESP} state_t;

    state_t state;
    logic port;
    logic use_2;
    logic [1:0] beat;
    logic hit;
    logic [1:0] off;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [DCACHE_SETS-1:0] valid_mem;
    logic [TAG_W-1:0] tag_mem [DCACHE_SETS];
    cache_pkg::word_t [3:0] data_mem [DCACHE_SETS];
    cache_pkg::word_t [3:0] line;
    cache_pkg::word_t data_q;
    cache_pkg::dbus_req_t cur;

    // port 1 first when idle, afterwards the latched port
    assign use_2 = (state == IDLE) ? !dreq_1.valid : port;
    assign cur = use_2 ? dreq_2 : dreq_1;

    assign off = cur.addr[3:2];
    assign idx = cur.addr[4 +: IDX_W];
    assign tag = cur.addr[31 -: TAG_W];
    assign hit = valid_mem[idx] && tag_mem[idx] == tag;

    always_comb begin
        line = data_mem[idx];
        if (state == FILL) begin
            line[beat] = dcresp.data;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            port <= 1'b0;
            beat <= '0;
            valid_mem <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cur.valid) begin
                        port <= use_2;
                        beat <= '0;
                        if (|cur.strobe) begin
                            state <= WRITE;
                        end else if (hit) begin
                            state <= RESP;
                        end else begin
                            state <= FILL;
                            valid_mem[idx] <= 1'b0;
                        end
                    end
                end
                FILL: begin
                    if (dcresp.ready) begin
                        beat <= beat + 2'd1;
                        if (dcresp.last) begin
                            state <= RESP;
                            valid_mem[idx] <= 1'b1;
                        end
                    end
                end
                WRITE: begin
                    if (dcresp.ready && dcresp.last) begin
                        state <= RESP;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        data_q <= line[off];
        if (state == FILL && dcresp.ready) begin
            data_mem[idx][beat] <= dcresp.data;
            tag_mem[idx] <= tag;
        end
        // store hit merges into the line, memory gets it on the bus
        if (state == IDLE && cur.valid && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (cur.strobe[b]) begin
                    data_mem[idx][off][8*b +: 8] <= cur.data[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        dcreq = '0;
        dcreq.valid = state == FILL || state == WRITE;
        if (state == WRITE) begin
            dcreq.is_write = 1'b1;
            dcreq.size = cur.size;
            dcreq.addr = cur.addr;
            dcreq.strobe = cur.strobe;
            dcreq.data = cur.data;
            dcreq.len = 2'd0;
        end else begin
            dcreq.size = cache_pkg::MSIZE_WORD;
            dcreq.addr = {cur.addr[31:4], 4'b0000};
            dcreq.len = 2'd3;
        end
    end

    assign dresp_1.addr_ok = state == RESP && !port;
    assign dresp_1.data_ok = state == RESP && !port;
    assign dresp_1.data = data_q;
    assign dresp_2.addr_ok = state == RESP && port;
    assign dresp_2.data_ok = state == RESP && port;
    assign dresp_2.data = data_q;

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ps

module icache #(
    parameter int ICACHE_SETS = 16
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  cache_pkg::ibus_req_t  ireq,
    output cache_pkg::ibus_resp_t iresp,
    output cache_pkg::cbus_req_t  icreq,
    input  cache_pkg::cbus_resp_t icresp
);

    localparam int IDX_W = $clog2(ICACHE_SETS);
    localparam int TAG_W = 32 - 4 - IDX_W;

    typedef enum logic {IDLE, FILL} state_t;

    state_t state;
    logic [1:0] beat;
    logic resp_q;
    logic hit;
    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic [ICACHE_SETS-1:0] valid_mem;
    logic [TAG_W-1:0] tag_mem [ICACHE_SETS];
    cache_pkg::word_t [3:0] data_mem [ICACHE_SETS];
    cache_pkg::word_t [3:0] line;
    cache_pkg::word_t [1:0] data_q;

    assign idx = ireq.addr[4 +: IDX_W];
    assign tag = ireq.addr[31 -: TAG_W];
    assign hit = valid_mem[idx] && tag_mem[idx] == tag;

    // line as it stands once the current beat lands
    always_comb begin
        line = data_mem[idx];
        if (state == FILL) begin
            line[beat] = icresp.data;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            beat <= '0;
            resp_q <= 1'b0;
            valid_mem <= '0;
        end else begin
            resp_q <= 1'b0;
            case (state)
                IDLE: begin
                    // skip the cycle where the old request answers
                    if (ireq.valid && !resp_q) begin
                        if (hit) begin
                            resp_q <= 1'b1;
                        end else begin
                            state <= FILL;
                            beat <= '0;
                            valid_mem[idx] <= 1'b0;
                        end
                    end
                end
                FILL: begin
                    if (icresp.ready) begin
                        beat <= beat + 2'd1;
                        if (icresp.last) begin
                            state <= IDLE;
                            valid_mem[idx] <= 1'b1;
                            resp_q <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        data_q <= ireq.addr[3] ? line[3:2] : line[1:0];
        if (state == FILL && icresp.ready) begin
            data_mem[idx][beat] <= icresp.data;
            tag_mem[idx] <= tag;
        end
    end

    always_comb begin
        icreq = '0;
        icreq.valid = state == FILL;
        icreq.size = cache_pkg::MSIZE_WORD;
        icreq.addr = {ireq.addr[31:4], 4'b0000};
        icreq.len = 2'd3;
    end

    assign iresp.addr_ok = resp_q;
    assign iresp.data_ok = resp_q;
    assign iresp.data = data_q;

    // pairs never cross a line
    a_fetch_aligned: assert property (@(posedge clk) disable iff (resetn)
        ireq.valid |-> ireq.addr[2:0] == 3'b000);

endmodule

// ==== verification/cache_manage_tb.sv ====
`timescale 1ns/1ps

module cache_manage_tb;

    localparam int ICACHE_SETS = 16;
    localparam int DCACHE_SETS = 16;
    // about sixty accesses of under twenty cycles each, with wide margin
    localparam int MAX_CYCLES = 4000;
    localparam logic [31:0] FILL_XOR = 32'h5a5a_0000;

    logic clk;
    logic resetn;
    cache_pkg::ibus_req_t  ireq;
    cache_pkg::ibus_resp_t iresp;
    cache_pkg::dbus_req_t  dreq_1;
    cache_pkg::dbus_resp_t dresp_1;
    cache_pkg::dbus_req_t  dreq_2;
    cache_pkg::dbus_resp_t dresp_2;
    cache_pkg::cbus_req_t  creq;
    cache_pkg::cbus_resp_t cresp;

    int cycles = 0;
    int tests = 0;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;
    integer seed = 32'h63b425b4;
    cache_pkg::word_t shadow [cache_pkg::addr_t];

    clock_gen clock_gen_i (
        .clk(clk),
        .resetn(resetn)
    );

    cache_manage #(
        .ICACHE_SETS(ICACHE_SETS),
        .DCACHE_SETS(DCACHE_SETS)
    ) cache_manage_i (
        .clk(clk),
        .resetn(resetn),
        .ireq(ireq),
        .iresp(iresp),
        .dreq_1(dreq_1),
        .dresp_1(dresp_1),
        .dreq_2(dreq_2),
        .dresp_2(dresp_2),
        .creq(creq),
        .cresp(cresp)
    );

    cbus_mem cbus_mem_i (
        .clk(clk),
        .resetn(resetn),
        .creq(creq),
        .cresp(cresp)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // kseg0 and kseg1 drop their top three bits
    function automatic cache_pkg::addr_t phys_addr(input cache_pkg::addr_t va);
        if (va[31:30] == 2'b10) begin
            return {3'b000, va[28:0]};
        end
        return va;
    endfunction

    function automatic cache_pkg::word_t mem_word(input cache_pkg::addr_t pa);
        cache_pkg::addr_t a;
        a = {pa[31:2], 2'b00};
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ FILL_XOR;
    endfunction

    task automatic record_store(input cache_pkg::addr_t pa, input cache_pkg::strobe_t strobe,
            input cache_pkg::word_t wdata);
        cache_pkg::word_t w;
        w = mem_word(pa);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        shadow[{pa[31:2], 2'b00}] = w;
    endtask

    task automatic compare_word(input string what, input cache_pkg::word_t got,
            input cache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    // addr_ok comes no later than data_ok
    task automatic check_addr_ok(input string what, input logic seen);
        checks++;
        if (!seen) begin
            $display("%s gave data_ok without an earlier addr_ok at %0t ns", what, $time);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic fetch_pair(input cache_pkg::addr_t va, output cache_pkg::word_t lo,
            output cache_pkg::word_t hi);
        logic addr_seen;
        addr_seen = 1'b0;
        @(posedge clk);
        ireq.valid <= 1'b1;
        ireq.addr <= va;
        @(posedge clk);
        while (!iresp.data_ok) begin
            addr_seen = addr_seen | iresp.addr_ok;
            @(posedge clk);
        end
        addr_seen = addr_seen | iresp.addr_ok;
        lo = iresp.data[0];
        hi = iresp.data[1];
        ireq.valid <= 1'b0;
        check_addr_ok("fetch port", addr_seen);
    endtask

    // zero strobe is a load
    task automatic data_access(input int port, input cache_pkg::addr_t va,
            input cache_pkg::strobe_t strobe, input cache_pkg::word_t wdata,
            output cache_pkg::word_t rdata);
        cache_pkg::dbus_req_t req;
        logic addr_seen;
        req.valid = 1'b1;
        req.addr = va;
        req.size = cache_pkg::MSIZE_WORD;
        req.strobe = strobe;
        req.data = wdata;
        addr_seen = 1'b0;
        @(posedge clk);
        if (port == 1) begin
            dreq_1 <= req;
        end else begin
            dreq_2 <= req;
        end
        @(posedge clk);
        while (!((port == 1) ? dresp_1.data_ok : dresp_2.data_ok)) begin
            addr_seen = addr_seen | ((port == 1) ? dresp_1.addr_ok : dresp_2.addr_ok);
            @(posedge clk);
        end
        addr_seen = addr_seen | ((port == 1) ? dresp_1.addr_ok : dresp_2.addr_ok);
        rdata = (port == 1) ? dresp_1.data : dresp_2.data;
        if (port == 1) begin
            dreq_1.valid <= 1'b0;
        end else begin
            dreq_2.valid <= 1'b0;
        end
        check_addr_ok((port == 1) ? "data port 1" : "data port 2", addr_seen);
        if (strobe != 4'b0000) begin
            record_store(phys_addr(va), strobe, wdata);
        end
    endtask

    task automatic fetch_miss_then_hit();
        cache_pkg::word_t lo;
        cache_pkg::word_t hi;
        fetch_pair(32'h8000_0100, lo, hi);
        compare_word("fetch miss low", lo, mem_word(32'h0000_0100));
        compare_word("fetch miss high", hi, mem_word(32'h0000_0104));
        fetch_pair(32'h8000_0100, lo, hi);
        compare_word("fetch hit low", lo, mem_word(32'h0000_0100));
        compare_word("fetch hit high", hi, mem_word(32'h0000_0104));
        // upper pair of the same line
        fetch_pair(32'h8000_0108, lo, hi);
        compare_word("fetch upper low", lo, mem_word(phys_addr(32'h8000_0108)));
        compare_word("fetch upper high", hi, mem_word(phys_addr(32'h8000_010c)));
        report_test("instruction fetch");
    endtask

    task automatic cached_store_then_load();
        cache_pkg::word_t rd;
        data_access(1, 32'h8000_0200, 4'b0000, '0, rd);
        compare_word("cached load before store", rd, mem_word(32'h0000_0200));
        data_access(1, 32'h8000_0200, 4'b0110, 32'hdead_beef, rd);
        data_access(1, 32'h8000_0200, 4'b0000, '0, rd);
        compare_word("cached load after store", rd, mem_word(32'h0000_0200));
        // memory behind the cache holds the same word
        data_access(1, 32'ha000_0200, 4'b0000, '0, rd);
        compare_word("uncached view of store", rd, mem_word(32'h0000_0200));
        report_test("cached store then load");
    endtask

    task automatic uncached_store_then_load();
        cache_pkg::word_t rd;
        data_access(2, 32'ha000_0300, 4'b1111, 32'h1234_5678, rd);
        data_access(2, 32'ha000_0300, 4'b0000, '0, rd);
        compare_word("uncached load", rd, mem_word(32'h0000_0300));
        report_test("uncached store and load");
    endtask

    task automatic dual_issue_paths();
        cache_pkg::word_t rd_1;
        cache_pkg::word_t rd_2;
        fork
            data_access(1, 32'h8000_0200, 4'b0000, '0, rd_1);
            data_access(2, 32'ha000_0304, 4'b0000, '0, rd_2);
        join
        compare_word("dual port 1 cached", rd_1, mem_word(32'h0000_0200));
        compare_word("dual port 2 uncached", rd_2, mem_word(32'h0000_0304));
        report_test("dual issue across paths");
    endtask

    task automatic bus_contention();
        cache_pkg::word_t lo;
        cache_pkg::word_t hi;
        cache_pkg::word_t rd_1;
        cache_pkg::word_t rd_2;
        int done_1;
        int done_2;
        fork
            fetch_pair(32'h8000_0400, lo, hi);
            begin
                data_access(1, 32'h8000_0500, 4'b0000, '0, rd_1);
                done_1 = cycles;
            end
            begin
                data_access(2, 32'h8000_0610, 4'b0000, '0, rd_2);
                done_2 = cycles;
            end
        join
        compare_word("contended fetch low", lo, mem_word(32'h0000_0400));
        compare_word("contended fetch high", hi, mem_word(32'h0000_0404));
        compare_word("contended port 1", rd_1, mem_word(32'h0000_0500));
        compare_word("contended port 2", rd_2, mem_word(32'h0000_0610));
        checks++;
        if (done_2 <= done_1) begin
            $display("dcache port 2 finished before port 1 at %0t ns", $time);
            test_errors++;
        end
        report_test("bus contention");
    endtask

    // cached and uncached halves of the window never overlap
    task automatic random_mix();
        logic [31:0] r;
        cache_pkg::addr_t va;
        cache_pkg::strobe_t strobe;
        cache_pkg::word_t wdata;
        cache_pkg::word_t rd;
        int port;
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            wdata = $random(seed);
            port = r[30] ? 2 : 1;
            strobe = r[12:9];
            if (strobe == 4'b0000) begin
                strobe = 4'b1111;
            end
            if (r[31]) begin
                va = 32'ha000_1200 + {23'd0, r[8:2], 2'b00};
            end else begin
                va = 32'h8000_1000 + {23'd0, r[8:2], 2'b00};
            end
            data_access(port, va, strobe, wdata, rd);
            data_access(port, va, 4'b0000, '0, rd);
            compare_word("random load", rd, mem_word(phys_addr(va)));
        end
        report_test("random mix");
    endtask

    initial begin
        ireq = '0;
        dreq_1 = '0;
        dreq_2 = '0;
        @(posedge clk);
        while (resetn) begin
            @(posedge clk);
        end
        fetch_miss_then_hit();
        cached_store_then_load();
        uncached_store_then_load();
        dual_issue_paths();
        bus_contention();
        random_mix();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== verification/cbus_mem.sv ====
`timescale 1ns/1ps

module cbus_mem (
    input  logic                  clk,
    input  logic                  resetn,
    input  cache_pkg::cbus_req_t  creq,
    output cache_pkg::cbus_resp_t cresp
);

    localparam int MEM_WORDS = 4096;
    localparam logic [31:0] FILL_XOR = 32'h5a5a_0000;

    logic active;
    logic [1:0] beat;
    cache_pkg::word_t mem [MEM_WORDS];

    function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old,
            input cache_pkg::strobe_t strobe, input cache_pkg::word_t wdata);
        cache_pkg::word_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    // each word starts as its byte address xor the pattern
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) << 2) ^ FILL_XOR;
        end
    end

    // ready is registered, so every beat after the first cycle is accepted
    always @(posedge clk) begin
        if (resetn) begin
            active <= 1'b0;
            beat <= '0;
            cresp <= '0;
        end else begin
            cresp <= '0;
            if (!active) begin
                if (creq.valid) begin
                    active <= 1'b1;
                    beat <= '0;
                    cresp.ready <= 1'b1;
                    cresp.last <= creq.len == 2'd0;
                    cresp.data <= mem[creq.addr[13:2]];
                end
            end else begin
                if (creq.is_write) begin
                    mem[creq.addr[13:2]] <= merge_bytes(mem[creq.addr[13:2]],
                        creq.strobe, creq.data);
                end
                if (cresp.last) begin
                    active <= 1'b0;
                end else begin
                    beat <= beat + 2'd1;
                    cresp.ready <= 1'b1;
                    cresp.last <= (beat + 2'd1) == creq.len;
                    cresp.data <= mem[creq.addr[13:4] * 4 + 12'(beat + 2'd1)];
                end
            end
        end
    end

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic resetn
);

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // reset is active high, released on a rising edge
    initial begin
        resetn = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b0;
    end

endmodule

// ==== vlog.f ====
src/cache_pkg.sv
src/icache.sv
src/dcache.sv
src/dbus_to_cbus.sv
src/cbus_arbiter.sv
src/cache_manage.sv
verification/clock_gen.sv
verification/cbus_mem.sv
verification/cache_manage_tb.sv
